// File: Makefile
TOP = controlTb

sim:
	verilator --binary --timing -f sources.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean

// File: sources.f
+incdir+tests
src/controlPkg.sv
src/instrDecoder.sv
src/controlSequencer.sv
src/controlOutputs.sv
src/mipsControl.sv
tests/controlTb.sv

// File: src/controlOutputs.sv
module controlOutputs
	import controlPkg::*;
(
	input  logic [stateWidth-1:0]    state,
	input  logic [opcodeWidth-1:0]   opcode,
	input  logic [functWidth-1:0]    funct,
	input  logic                     eq,
	input  logic                     gt,
	input  logic                     lt,
	output logic                     pcWrite,
	output logic                     memRead,
	output logic                     memWrite,
	output logic                     irWrite,
	output logic                     regWrite,
	output logic                     aluOutWrite,
	output logic                     mdrWrite,
	output logic                     shiftSrc,
	output logic                     shiftAmtSrc,
	output logic                     hiLoSel,
	output logic                     halted,
	output logic [pcSrcWidth-1:0]    pcSrc,
	output logic [iOrDWidth-1:0]     iOrD,
	output logic [regDstWidth-1:0]   regDst,
	output logic [aluSrcAWidth-1:0]  aluSrcA,
	output logic [sizeSelWidth-1:0]  sizeSel,
	output logic [aluSrcBWidth-1:0]  aluSrcB,
	output logic [aluOpWidth-1:0]    aluOp,
	output logic [memToRegWidth-1:0] memToReg,
	output logic [shiftOpWidth-1:0]  shiftOp
);

	logic                    isStore;
	logic                    constShift;
	logic                    branchTaken;
	logic [sizeSelWidth-1:0] accessSize;
	logic [iOrDWidth-1:0]    dataAddr;
	logic [shiftOpWidth-1:0] shiftKind;

	assign isStore = (opcode == opSb) || (opcode == opSh) || (opcode == opSw);
	assign constShift = (funct == fnSll) || (funct == fnSrl) || (funct == fnSra);
	assign dataAddr = isStore ? addrStore : addrLoad;

	assign accessSize = ((opcode == opLb) || (opcode == opSb)) ? sizeByte :
		((opcode == opLh) || (opcode == opSh)) ? sizeHalf : sizeWord;

	assign shiftKind = ((funct == fnSll) || (funct == fnSllv)) ? shLeft :
		(funct == fnSrl) ? shRightLogic : shRightArith;

	always_comb
	begin
		case (opcode)
			opBeq: branchTaken = eq;
			opBne: branchTaken = !eq;
			opBle: branchTaken = lt || eq;
			opBgt: branchTaken = gt;
			default: branchTaken = 1'b0;
		endcase
	end

	always_comb
	begin
		pcWrite = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		irWrite = 1'b0;
		regWrite = 1'b0;
		aluOutWrite = 1'b0;
		mdrWrite = 1'b0;
		shiftSrc = 1'b0;
		shiftAmtSrc = 1'b0;
		hiLoSel = 1'b0;
		halted = 1'b0;
		pcSrc = pcFromAlu;
		iOrD = addrPc;
		regDst = dstRt;
		aluSrcA = srcAPc;
		sizeSel = sizeWord;
		aluSrcB = srcBRegB;
		aluOp = aluPass;
		memToReg = wbAluOut;
		shiftOp = shNone;
		case (state)
			stResetInit:
			begin
				regWrite = 1'b1; // stack pointer gets its start value
				regDst = dstStackPtr;
				memToReg = wbStackInit;
			end
			stFetch:
			begin
				memRead = 1'b1;
				irWrite = 1'b1;
				pcWrite = 1'b1; // pc + 4
				aluSrcB = srcBFour;
				aluOp = aluAdd;
			end
			stFetchWait: irWrite = 1'b1;
			stDecode:
			begin
				// branch target computed early
				aluSrcB = srcBBranchOff;
				aluOp = aluAdd;
				aluOutWrite = 1'b1;
			end
			stAddExec,
			stSubExec,
			stAndExec:
			begin
				aluSrcA = srcARegA;
				aluOp = (state == stAddExec) ? aluAdd :
					(state == stSubExec) ? aluSub : aluAnd;
				aluOutWrite = 1'b1;
			end
			stAluWriteback:
			begin
				regWrite = 1'b1;
				regDst = dstRd;
			end
			stSltWrite:
			begin
				aluSrcA = srcARegA;
				aluOp = aluCompare;
				regWrite = 1'b1;
				regDst = dstRd;
				memToReg = wbCompare;
			end
			stShiftLoadReg: shiftOp = shLoad;
			stShiftLoadShamt:
			begin
				shiftOp = shLoad;
				shiftSrc = 1'b1;
				shiftAmtSrc = 1'b1; // shamt field
			end
			stShiftOp:
			begin
				shiftOp = shiftKind;
				shiftSrc = constShift;
				shiftAmtSrc = constShift;
			end
			stShiftWriteback:
			begin
				regWrite = 1'b1;
				regDst = dstRd;
				memToReg = wbShiftReg;
			end
			stMoveHi,
			stMoveLo:
			begin
				regWrite = 1'b1;
				regDst = dstRd;
				memToReg = wbHiLo;
				hiLoSel = (state == stMoveLo);
			end
			stJumpReg:
			begin
				aluSrcA = srcARegA;
				pcWrite = 1'b1;
			end
			stBreak:
			begin
				aluSrcB = srcBFour;
				aluOp = aluSub; // back onto itself
				pcWrite = 1'b1;
			end
			stReturnExc: halted = 1'b0;
			stLui:
			begin
				aluSrcB = srcBImm;
				regWrite = 1'b1;
				memToReg = wbUpperImm;
			end
			stSlti:
			begin
				aluSrcA = srcARegA;
				aluSrcB = srcBImm;
				aluOp = aluCompare;
				regWrite = 1'b1;
				memToReg = wbCompare;
			end
			stImmExec,
			stAddrCalc:
			begin
				aluSrcA = srcARegA;
				aluSrcB = srcBImm;
				aluOp = aluAdd;
				aluOutWrite = 1'b1;
			end
			stImmWriteback:
			begin
				aluSrcB = srcBImm;
				regWrite = 1'b1;
			end
			stMemRead:
			begin
				iOrD = dataAddr;
				memRead = 1'b1; // stores read too, for sub-word merge
			end
			stMemWait:
			begin
				iOrD = dataAddr;
				mdrWrite = 1'b1;
			end
			stLoadWriteback:
			begin
				iOrD = addrLoad;
				sizeSel = accessSize;
				regWrite = 1'b1;
				memToReg = (opcode == opLw) ? wbMemWord : wbSizedData;
			end
			stStoreWrite:
			begin
				iOrD = addrStore;
				sizeSel = accessSize;
				memWrite = 1'b1;
			end
			stBranch:
			begin
				aluSrcA = srcARegA;
				aluOp = ((opcode == opBle) || (opcode == opBgt)) ? aluCompare : aluSub;
				pcSrc = pcFromAluOut;
				pcWrite = branchTaken;
			end
			default: halted = 1'b1; // stHalt
		endcase
	end

endmodule

// File: src/controlPkg.sv
package controlPkg;

	localparam int stateWidth = 6;
	localparam int opcodeWidth = 6;
	localparam int functWidth = 6;

	localparam int aluOpWidth = 3;
	localparam int aluSrcAWidth = 2;
	localparam int aluSrcBWidth = 3;
	localparam int iOrDWidth = 2;
	localparam int pcSrcWidth = 2;
	localparam int memToRegWidth = 3;
	localparam int regDstWidth = 2;
	localparam int shiftOpWidth = 3;
	localparam int sizeSelWidth = 2;

	// sequencer states
	localparam logic [stateWidth-1:0] stResetInit = 6'd0;
	localparam logic [stateWidth-1:0] stFetch = 6'd1;
	localparam logic [stateWidth-1:0] stFetchWait = 6'd2;
	localparam logic [stateWidth-1:0] stDecode = 6'd3;
	localparam logic [stateWidth-1:0] stAddExec = 6'd4;
	localparam logic [stateWidth-1:0] stSubExec = 6'd5;
	localparam logic [stateWidth-1:0] stAndExec = 6'd6;
	localparam logic [stateWidth-1:0] stAluWriteback = 6'd7;
	localparam logic [stateWidth-1:0] stSltWrite = 6'd8;
	localparam logic [stateWidth-1:0] stShiftLoadReg = 6'd9;
	localparam logic [stateWidth-1:0] stShiftLoadShamt = 6'd10;
	localparam logic [stateWidth-1:0] stShiftOp = 6'd11;
	localparam logic [stateWidth-1:0] stShiftWriteback = 6'd12;
	localparam logic [stateWidth-1:0] stMoveHi = 6'd13;
	localparam logic [stateWidth-1:0] stMoveLo = 6'd14;
	localparam logic [stateWidth-1:0] stJumpReg = 6'd15;
	localparam logic [stateWidth-1:0] stBreak = 6'd16;
	localparam logic [stateWidth-1:0] stReturnExc = 6'd17;
	localparam logic [stateWidth-1:0] stLui = 6'd18;
	localparam logic [stateWidth-1:0] stSlti = 6'd19;
	localparam logic [stateWidth-1:0] stImmExec = 6'd20;
	localparam logic [stateWidth-1:0] stImmWriteback = 6'd21;
	localparam logic [stateWidth-1:0] stAddrCalc = 6'd22;
	localparam logic [stateWidth-1:0] stMemRead = 6'd23;
	localparam logic [stateWidth-1:0] stMemWait = 6'd24;
	localparam logic [stateWidth-1:0] stLoadWriteback = 6'd25;
	localparam logic [stateWidth-1:0] stStoreWrite = 6'd26;
	localparam logic [stateWidth-1:0] stBranch = 6'd27;
	localparam logic [stateWidth-1:0] stHalt = 6'd63;

	// primary opcodes
	localparam logic [opcodeWidth-1:0] opRType = 6'h00;
	localparam logic [opcodeWidth-1:0] opBeq = 6'h04;
	localparam logic [opcodeWidth-1:0] opBne = 6'h05;
	localparam logic [opcodeWidth-1:0] opBle = 6'h06;
	localparam logic [opcodeWidth-1:0] opBgt = 6'h07;
	localparam logic [opcodeWidth-1:0] opAddi = 6'h08;
	localparam logic [opcodeWidth-1:0] opAddiu = 6'h09;
	localparam logic [opcodeWidth-1:0] opSlti = 6'h0a;
	localparam logic [opcodeWidth-1:0] opLui = 6'h0f;
	localparam logic [opcodeWidth-1:0] opLb = 6'h20;
	localparam logic [opcodeWidth-1:0] opLh = 6'h21;
	localparam logic [opcodeWidth-1:0] opLw = 6'h23;
	localparam logic [opcodeWidth-1:0] opSb = 6'h28;
	localparam logic [opcodeWidth-1:0] opSh = 6'h29;
	localparam logic [opcodeWidth-1:0] opSw = 6'h2b;

	// R-type funct field
	localparam logic [functWidth-1:0] fnSll = 6'h00;
	localparam logic [functWidth-1:0] fnSrl = 6'h02;
	localparam logic [functWidth-1:0] fnSra = 6'h03;
	localparam logic [functWidth-1:0] fnSllv = 6'h04;
	localparam logic [functWidth-1:0] fnSrav = 6'h07;
	localparam logic [functWidth-1:0] fnJr = 6'h08;
	localparam logic [functWidth-1:0] fnBreak = 6'h0d;
	localparam logic [functWidth-1:0] fnMfhi = 6'h10;
	localparam logic [functWidth-1:0] fnMflo = 6'h12;
	localparam logic [functWidth-1:0] fnRte = 6'h13;
	localparam logic [functWidth-1:0] fnAdd = 6'h20;
	localparam logic [functWidth-1:0] fnSub = 6'h22;
	localparam logic [functWidth-1:0] fnAnd = 6'h24;
	localparam logic [functWidth-1:0] fnSlt = 6'h2a;

	localparam logic [aluOpWidth-1:0] aluPass = 3'd0;
	localparam logic [aluOpWidth-1:0] aluAdd = 3'd1;
	localparam logic [aluOpWidth-1:0] aluSub = 3'd2;
	localparam logic [aluOpWidth-1:0] aluAnd = 3'd3;
	localparam logic [aluOpWidth-1:0] aluCompare = 3'd7;

	localparam logic [aluSrcAWidth-1:0] srcAPc = 2'd0;
	localparam logic [aluSrcAWidth-1:0] srcARegA = 2'd1;

	localparam logic [aluSrcBWidth-1:0] srcBRegB = 3'd0;
	localparam logic [aluSrcBWidth-1:0] srcBFour = 3'd1;
	localparam logic [aluSrcBWidth-1:0] srcBImm = 3'd2;
	localparam logic [aluSrcBWidth-1:0] srcBBranchOff = 3'd3; // sign-extended imm << 2

	localparam logic [iOrDWidth-1:0] addrPc = 2'd0;
	localparam logic [iOrDWidth-1:0] addrLoad = 2'd1;
	localparam logic [iOrDWidth-1:0] addrStore = 2'd2;

	localparam logic [pcSrcWidth-1:0] pcFromAlu = 2'd0;
	localparam logic [pcSrcWidth-1:0] pcFromAluOut = 2'd1;

	localparam logic [memToRegWidth-1:0] wbAluOut = 3'd0;
	localparam logic [memToRegWidth-1:0] wbMemWord = 3'd1;
	localparam logic [memToRegWidth-1:0] wbSizedData = 3'd2;
	localparam logic [memToRegWidth-1:0] wbHiLo = 3'd3;
	localparam logic [memToRegWidth-1:0] wbUpperImm = 3'd4;
	localparam logic [memToRegWidth-1:0] wbCompare = 3'd5;
	localparam logic [memToRegWidth-1:0] wbStackInit = 3'd6;
	localparam logic [memToRegWidth-1:0] wbShiftReg = 3'd7;

	localparam logic [regDstWidth-1:0] dstRt = 2'd0;
	localparam logic [regDstWidth-1:0] dstRd = 2'd1;
	localparam logic [regDstWidth-1:0] dstStackPtr = 2'd2; // r29

	localparam logic [shiftOpWidth-1:0] shNone = 3'd0;
	localparam logic [shiftOpWidth-1:0] shLoad = 3'd1;
	localparam logic [shiftOpWidth-1:0] shLeft = 3'd2;
	localparam logic [shiftOpWidth-1:0] shRightLogic = 3'd3;
	localparam logic [shiftOpWidth-1:0] shRightArith = 3'd4;

	localparam logic [sizeSelWidth-1:0] sizeWord = 2'd0;
	localparam logic [sizeSelWidth-1:0] sizeHalf = 2'd1;
	localparam logic [sizeSelWidth-1:0] sizeByte = 2'd2;

endpackage

// File: src/controlSequencer.sv
module controlSequencer
	import controlPkg::*;
(
	input  logic                   Clock,
	input  logic                   rstN,
	input  logic [opcodeWidth-1:0] opcode,
	input  logic [functWidth-1:0]  funct,
	output logic [stateWidth-1:0]  state
);

	logic [stateWidth-1:0] nextState;
	logic [stateWidth-1:0] dispatchState;
	logic                  illegal;
	logic                  isStore;

	instrDecoder uDecoder (
		.opcode        (opcode),
		.funct         (funct),
		.dispatchState (dispatchState),
		.illegal       (illegal)
	);

	assign isStore = (opcode == opSb) || (opcode == opSh) || (opcode == opSw);

	always_comb
	begin
		case (state)
			stResetInit: nextState = stFetch;
			stFetch: nextState = stFetchWait;
			stFetchWait: nextState = stDecode;
			stDecode: nextState = illegal ? stHalt : dispatchState;

			stAddExec,
			stSubExec,
			stAndExec: nextState = stAluWriteback;

			// shifts run load, operate, write back
			stShiftLoadReg,
			stShiftLoadShamt: nextState = stShiftOp;
			stShiftOp: nextState = stShiftWriteback;

			stImmExec: nextState = stImmWriteback;

			stAddrCalc: nextState = stMemRead;
			stMemRead: nextState = stMemWait;
			stMemWait: nextState = isStore ? stStoreWrite : stLoadWriteback;

			stAluWriteback,
			stSltWrite,
			stShiftWriteback,
			stMoveHi,
			stMoveLo,
			stJumpReg,
			stBreak,
			stReturnExc,
			stLui,
			stSlti,
			stImmWriteback,
			stLoadWriteback,
			stStoreWrite,
			stBranch: nextState = stFetch;

			stHalt: nextState = stHalt; // only reset leaves
			default: nextState = stHalt;
		endcase
	end

	always_ff @(posedge Clock)
	begin
		if (!rstN)
			state <= stResetInit;
		else
			state <= nextState;
	end

endmodule

// File: src/instrDecoder.sv
module instrDecoder
	import controlPkg::*;
(
	input  logic [opcodeWidth-1:0] opcode,
	input  logic [functWidth-1:0]  funct,
	output logic [stateWidth-1:0]  dispatchState,
	output logic                   illegal
);

	always_comb
	begin
		dispatchState = stHalt;
		illegal = 1'b0;
		case (opcode)
			opRType:
			begin
				case (funct)
					fnAdd: dispatchState = stAddExec;
					fnSub: dispatchState = stSubExec;
					fnAnd: dispatchState = stAndExec;
					fnSlt: dispatchState = stSltWrite;
					fnSllv,
					fnSrav: dispatchState = stShiftLoadReg; // amount from rs
					fnSll,
					fnSrl,
					fnSra: dispatchState = stShiftLoadShamt;
					fnMfhi: dispatchState = stMoveHi;
					fnMflo: dispatchState = stMoveLo;
					fnJr: dispatchState = stJumpReg;
					fnBreak: dispatchState = stBreak;
					fnRte: dispatchState = stReturnExc;
					default: illegal = 1'b1;
				endcase
			end
			opLui: dispatchState = stLui;
			opSlti: dispatchState = stSlti;
			opAddi,
			opAddiu: dispatchState = stImmExec;
			opLb,
			opLh,
			opLw,
			opSb,
			opSh,
			opSw: dispatchState = stAddrCalc; // loads and stores share the address path
			opBeq,
			opBne,
			opBle,
			opBgt: dispatchState = stBranch;
			default: illegal = 1'b1;
		endcase
	end

endmodule

// File: src/mipsControl.sv
module mipsControl
	import controlPkg::*;
(
	input  logic                     Clock,
	input  logic                     rstN,
	input  logic [opcodeWidth-1:0]   opcode,
	input  logic [functWidth-1:0]    funct,
	input  logic                     eq,
	input  logic                     gt,
	input  logic                     lt,
	output logic [stateWidth-1:0]    state,
	output logic                     pcWrite,
	output logic                     memRead,
	output logic                     memWrite,
	output logic                     irWrite,
	output logic                     regWrite,
	output logic                     aluOutWrite,
	output logic                     mdrWrite,
	output logic                     shiftSrc,
	output logic                     shiftAmtSrc,
	output logic                     hiLoSel,
	output logic                     halted,
	output logic [pcSrcWidth-1:0]    pcSrc,
	output logic [iOrDWidth-1:0]     iOrD,
	output logic [regDstWidth-1:0]   regDst,
	output logic [aluSrcAWidth-1:0]  aluSrcA,
	output logic [sizeSelWidth-1:0]  sizeSel,
	output logic [aluSrcBWidth-1:0]  aluSrcB,
	output logic [aluOpWidth-1:0]    aluOp,
	output logic [memToRegWidth-1:0] memToReg,
	output logic [shiftOpWidth-1:0]  shiftOp
);

	controlSequencer uSequencer (
		.Clock  (Clock),
		.rstN   (rstN),
		.opcode (opcode),
		.funct  (funct),
		.state  (state)
	);

	// control word straight from the current state
	controlOutputs uOutputs (
		.state       (state),
		.opcode      (opcode),
		.funct       (funct),
		.eq          (eq),
		.gt          (gt),
		.lt          (lt),
		.pcWrite     (pcWrite),
		.memRead     (memRead),
		.memWrite    (memWrite),
		.irWrite     (irWrite),
		.regWrite    (regWrite),
		.aluOutWrite (aluOutWrite),
		.mdrWrite    (mdrWrite),
		.shiftSrc    (shiftSrc),
		.shiftAmtSrc (shiftAmtSrc),
		.hiLoSel     (hiLoSel),
		.halted      (halted),
		.pcSrc       (pcSrc),
		.iOrD        (iOrD),
		.regDst      (regDst),
		.aluSrcA     (aluSrcA),
		.sizeSel     (sizeSel),
		.aluSrcB     (aluSrcB),
		.aluOp       (aluOp),
		.memToReg    (memToReg),
		.shiftOp     (shiftOp)
	);

endmodule

// File: tests/controlChecks.svh
`ifndef CONTROL_CHECKS_SVH
`define CONTROL_CHECKS_SVH

task automatic checkState(input logic [stateWidth-1:0] expected,
	input logic [stateWidth-1:0] actual);
	if (actual !== expected)
		abortRun($sformatf("ERR %s state: expected %0d, actual %0d", testName, expected, actual));
endtask

task automatic checkBit(input string sig, input logic expected, input logic actual);
	if (actual !== expected)
		abortRun($sformatf("ERR %s %s: expected %0b, actual %0b", testName, sig, expected, actual));
endtask

// every 2-bit select shares this width
task automatic checkSel2(input string sig, input logic [sizeSelWidth-1:0] expected,
	input logic [sizeSelWidth-1:0] actual);
	if (actual !== expected)
		abortRun($sformatf("ERR %s %s: expected %0d, actual %0d", testName, sig, expected, actual));
endtask

task automatic checkSel3(input string sig, input logic [aluOpWidth-1:0] expected,
	input logic [aluOpWidth-1:0] actual);
	if (actual !== expected)
		abortRun($sformatf("ERR %s %s: expected %0d, actual %0d", testName, sig, expected, actual));
endtask

// one cycle on, sampled mid-period
task automatic stepTo(input logic [stateWidth-1:0] expected);
	@(negedge Clock);
	checkState(expected, state);
endtask

task automatic checkResetState();
	checkState(stResetInit, state);
	checkBit("regWrite", 1'b1, regWrite);
	checkSel2("regDst", dstStackPtr, regDst);
	checkSel3("memToReg", wbStackInit, memToReg);
	checkBit("pcWrite", 1'b0, pcWrite);
	checkBit("memRead", 1'b0, memRead);
	checkBit("memWrite", 1'b0, memWrite);
	checkBit("irWrite", 1'b0, irWrite);
	checkBit("halted", 1'b0, halted);
endtask

task automatic checkHaltState();
	checkState(stHalt, state);
	checkBit("halted", 1'b1, halted);
	checkBit("pcWrite", 1'b0, pcWrite);
	checkBit("memWrite", 1'b0, memWrite);
	checkBit("regWrite", 1'b0, regWrite);
	checkBit("irWrite", 1'b0, irWrite);
	checkBit("aluOutWrite", 1'b0, aluOutWrite);
	checkBit("mdrWrite", 1'b0, mdrWrite);
endtask

// new instruction in fetch, then walk wait and decode
task automatic startInstr(input string name, input logic [opcodeWidth-1:0] op,
	input logic [functWidth-1:0] fn, input logic [2:0] flags);
	@(posedge Clock);
	#1;
	testName = name;
	opcode = op;
	funct = fn;
	{eq, gt, lt} = flags;
	@(negedge Clock);
	checkState(stFetch, state);
	checkBit("memRead", 1'b1, memRead);
	checkBit("irWrite", 1'b1, irWrite);
	checkBit("pcWrite", 1'b1, pcWrite);
	checkSel3("aluSrcB", srcBFour, aluSrcB);
	checkSel3("aluOp", aluAdd, aluOp);
	stepTo(stFetchWait);
	stepTo(stDecode);
endtask

`endif

// File: tests/controlTb.sv
module controlTb
	import controlPkg::*;
();

	localparam int maxCycles = 2000; // ~45 instructions of up to 7 cycles, plus resets

	logic Clock;
	logic rstN;
	logic [opcodeWidth-1:0] opcode;
	logic [functWidth-1:0] funct;
	logic eq;
	logic gt;
	logic lt;
	logic [stateWidth-1:0] state;
	logic pcWrite, memRead, memWrite, irWrite, regWrite, aluOutWrite;
	logic mdrWrite, shiftSrc, shiftAmtSrc, hiLoSel, halted;
	logic [pcSrcWidth-1:0] pcSrc;
	logic [iOrDWidth-1:0] iOrD;
	logic [regDstWidth-1:0] regDst;
	logic [aluSrcAWidth-1:0] aluSrcA;
	logic [sizeSelWidth-1:0] sizeSel;
	logic [aluSrcBWidth-1:0] aluSrcB;
	logic [aluOpWidth-1:0] aluOp;
	logic [memToRegWidth-1:0] memToReg;
	logic [shiftOpWidth-1:0] shiftOp;

	string testName;
	integer seed = 36;
	int cycleCount = 0;

	mipsControl u_dut (.*);

	always #5 Clock = ~Clock;

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("Test FAILED");
		$fatal(1);
	endtask

	always @(posedge Clock)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount > maxCycles)
			abortRun("simulation ran past its cycle limit without finishing");
	end

	`include "controlChecks.svh"

	task automatic pulseReset();
		rstN = 1'b0;
		repeat (4) @(posedge Clock);
		#1;
		rstN = 1'b1;
		@(negedge Clock);
		checkResetState();
	endtask

	task automatic aluTest(input string name, input logic [functWidth-1:0] fn,
		input logic [stateWidth-1:0] execSt, input logic [aluOpWidth-1:0] expOp);
		startInstr(name, opRType, fn, 3'b000);
		stepTo(execSt);
		checkSel2("aluSrcA", srcARegA, aluSrcA);
		checkSel3("aluOp", expOp, aluOp);
		stepTo(stAluWriteback);
		checkBit("regWrite", 1'b1, regWrite);
		checkSel2("regDst", dstRd, regDst);
		checkSel3("memToReg", wbAluOut, memToReg);
	endtask

	// slt, mfhi, mflo write in their only state
	task automatic writeTest(input string name, input logic [functWidth-1:0] fn,
		input logic [stateWidth-1:0] st, input logic [memToRegWidth-1:0] expWb,
		input logic expHiLo);
		startInstr(name, opRType, fn, 3'b000);
		stepTo(st);
		checkBit("regWrite", 1'b1, regWrite);
		checkSel2("regDst", dstRd, regDst);
		checkSel3("memToReg", expWb, memToReg);
		checkBit("hiLoSel", expHiLo, hiLoSel);
	endtask

	task automatic shiftTest(input string name, input logic [functWidth-1:0] fn,
		input logic isConst, input logic [shiftOpWidth-1:0] expOp);
		startInstr(name, opRType, fn, 3'b000);
		stepTo(isConst ? stShiftLoadShamt : stShiftLoadReg);
		checkSel3("shiftOp", shLoad, shiftOp);
		checkBit("shiftSrc", isConst, shiftSrc);
		checkBit("shiftAmtSrc", isConst, shiftAmtSrc);
		stepTo(stShiftOp);
		checkSel3("shiftOp", expOp, shiftOp);
		checkBit("shiftSrc", isConst, shiftSrc);
		checkBit("shiftAmtSrc", isConst, shiftAmtSrc);
		stepTo(stShiftWriteback);
		checkBit("regWrite", 1'b1, regWrite);
		checkSel2("regDst", dstRd, regDst);
	endtask

	task automatic jumpTest(input string name, input logic [functWidth-1:0] fn,
		input logic [stateWidth-1:0] st, input logic expPc);
		startInstr(name, opRType, fn, 3'b000);
		stepTo(st);
		checkBit("pcWrite", expPc, pcWrite);
	endtask

	task automatic immTest(input string name, input logic [opcodeWidth-1:0] op,
		input logic [stateWidth-1:0] firstSt, input logic [stateWidth-1:0] wbSt,
		input logic [memToRegWidth-1:0] expWb);
		startInstr(name, op, 6'd0, 3'b000);
		stepTo(firstSt);
		checkSel3("aluSrcB", srcBImm, aluSrcB);
		if (firstSt != wbSt)
			stepTo(wbSt);
		checkBit("regWrite", 1'b1, regWrite);
		checkSel2("regDst", dstRt, regDst);
		checkSel3("aluSrcB", srcBImm, aluSrcB);
		checkSel3("memToReg", expWb, memToReg);
	endtask

	task automatic checkMemStrobes(input logic expMemWrite, input logic expRegWrite);
		checkBit("memWrite", expMemWrite, memWrite);
		checkBit("regWrite", expRegWrite, regWrite);
	endtask

	task automatic memTest(input string name, input logic [opcodeWidth-1:0] op,
		input logic isStore, input logic [sizeSelWidth-1:0] expSize);
		logic [iOrDWidth-1:0] expAddr;
		expAddr = isStore ? addrStore : addrLoad;
		startInstr(name, op, 6'd0, 3'b000);
		stepTo(stAddrCalc);
		checkMemStrobes(1'b0, 1'b0);
		stepTo(stMemRead);
		checkSel2("iOrD", expAddr, iOrD);
		checkMemStrobes(1'b0, 1'b0);
		stepTo(stMemWait);
		checkSel2("iOrD", expAddr, iOrD);
		checkBit("mdrWrite", 1'b1, mdrWrite);
		checkMemStrobes(1'b0, 1'b0);
		stepTo(isStore ? stStoreWrite : stLoadWriteback);
		checkSel2("sizeSel", expSize, sizeSel);
		checkMemStrobes(isStore, !isStore);
	endtask

	task automatic branchTest(input string name, input logic [opcodeWidth-1:0] op);
		int rnd;
		logic [2:0] flags; // eq, gt, lt
		logic taken;
		logic [aluOpWidth-1:0] expOp;
		rnd = $random(seed);
		flags = rnd[2:0];
		case (op)
			opBeq:
			begin
				taken = flags[2];
				expOp = aluSub;
			end
			opBne:
			begin
				taken = !flags[2];
				expOp = aluSub;
			end
			opBle:
			begin
				taken = flags[0] || flags[2];
				expOp = aluCompare;
			end
			default:
			begin
				taken = flags[1];
				expOp = aluCompare;
			end
		endcase
		startInstr(name, op, 6'd0, flags);
		stepTo(stBranch);
		checkBit("pcWrite", taken, pcWrite);
		checkSel2("pcSrc", pcFromAluOut, pcSrc);
		checkSel2("aluSrcA", srcARegA, aluSrcA);
		checkSel3("aluOp", expOp, aluOp);
	endtask

	task automatic illegalTest(input string name, input logic [opcodeWidth-1:0] op,
		input logic [functWidth-1:0] fn);
		startInstr(name, op, fn, 3'b000);
		repeat (11) // entry plus 10 held cycles
		begin
			stepTo(stHalt);
			checkHaltState();
		end
		@(posedge Clock);
		#1;
		pulseReset();
	endtask

	initial
	begin
		Clock = 1'b0;
		opcode = opRType;
		funct = fnAdd;
		eq = 1'b0;
		gt = 1'b0;
		lt = 1'b0;
		testName = "reset";
		pulseReset();
		aluTest("add", fnAdd, stAddExec, aluAdd);
		aluTest("sub", fnSub, stSubExec, aluSub);
		aluTest("and", fnAnd, stAndExec, aluAnd);
		writeTest("slt", fnSlt, stSltWrite, wbCompare, 1'b0);
		writeTest("mfhi", fnMfhi, stMoveHi, wbHiLo, 1'b0);
		writeTest("mflo", fnMflo, stMoveLo, wbHiLo, 1'b1);
		shiftTest("sll", fnSll, 1'b1, shLeft);
		shiftTest("srl", fnSrl, 1'b1, shRightLogic);
		shiftTest("sra", fnSra, 1'b1, shRightArith);
		shiftTest("sllv", fnSllv, 1'b0, shLeft);
		shiftTest("srav", fnSrav, 1'b0, shRightArith);
		jumpTest("jr", fnJr, stJumpReg, 1'b1);
		jumpTest("break", fnBreak, stBreak, 1'b1);
		jumpTest("rte", fnRte, stReturnExc, 1'b0);
		immTest("addi", opAddi, stImmExec, stImmWriteback, wbAluOut);
		immTest("addiu", opAddiu, stImmExec, stImmWriteback, wbAluOut);
		immTest("lui", opLui, stLui, stLui, wbUpperImm);
		immTest("slti", opSlti, stSlti, stSlti, wbCompare);
		memTest("lb", opLb, 1'b0, sizeByte);
		memTest("lh", opLh, 1'b0, sizeHalf);
		memTest("lw", opLw, 1'b0, sizeWord);
		memTest("sb", opSb, 1'b1, sizeByte);
		memTest("sh", opSh, 1'b1, sizeHalf);
		memTest("sw", opSw, 1'b1, sizeWord);
		repeat (6)
		begin
			branchTest("beq", opBeq);
			branchTest("bne", opBne);
			branchTest("ble", opBle);
			branchTest("bgt", opBgt);
		end
		illegalTest("bad opcode", 6'h02, fnAdd);
		illegalTest("bad funct", opRType, 6'h18); // mult, not implemented
		$display("Test OK");
		$finish;
	end

endmodule
